//--- Makefile
# Verilator build, run, lint and clean for the RFFE master

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f rffe_master.f --top-module tb_rffe_master

run: build
	./obj_dir/Vtb_rffe_master | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing --assert -f rffe_master.f --top-module tb_rffe_master

clean:
	rm -rf obj_dir sim.log

//--- rffe_clk_div.sv
// bit-period counter, bit tick and bus clock generation
`include "rffe_macros.svh"

module rffe_clk_div (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_set,
   input  logic [`RFFE_DIV_W-1:0] i_div,
   input  logic                   i_active,
   output logic                   o_bit_tick,
   output logic                   o_sclk
);

   logic [`RFFE_DIV_W-1:0] per_q;
   logic [`RFFE_DIV_W-1:0] cnt_q;
   logic [`RFFE_DIV_W-1:0] div_lim;
   logic [`RFFE_DIV_W-1:0] hi_start;

   // clamp to the fastest legal period
   assign div_lim = (i_div < `RFFE_DIV_W'(`RFFE_DIV_MIN)) ?
                    `RFFE_DIV_W'(`RFFE_DIV_MIN) : i_div;

   ////////////////////
   // down-counter, one bit per period
   always_ff @(posedge clk) begin
      if (i_rst) begin
         per_q <= `RFFE_DIV_W'(`RFFE_DIV_RESET);
         cnt_q <= `RFFE_DIV_W'(`RFFE_DIV_RESET - 1);
      end else if (i_set) begin
         per_q <= div_lim;
         cnt_q <= div_lim - 1'b1;
      end else if (cnt_q == '0) begin
         cnt_q <= per_q - 1'b1;
      end else begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // last cycle of each bit
   assign o_bit_tick = (cnt_q == '0);

   ////////////////////
   // bit starts at per-1, high for floor(per/2) cycles
   assign hi_start = per_q - (per_q >> 1);
   assign o_sclk   = i_active && (cnt_q >= hi_start);

endmodule

//--- rffe_frame_buf.sv
// 32-byte dual-port frame buffer, host port a and engine port b
`include "rffe_macros.svh"

module rffe_frame_buf (
   input  logic                   clk,
   input  logic                   i_host_wr,
   input  logic [`RFFE_BUF_AW-1:0] i_host_addr,
   input  logic [`RFFE_BUF_DW-1:0] i_host_wdata,
   output logic [`RFFE_BUF_DW-1:0] o_host_rdata,
   input  logic                   i_busy,
   rffe_buf_if.mem                eng
);

   logic [`RFFE_BUF_DW-1:0] mem_q [`RFFE_BUF_DEPTH];
   logic                    host_we;

   // host locked out while a frame runs
   assign host_we = i_host_wr && !i_busy;

   ////////////////////
   // write side of both ports
   always_ff @(posedge clk) begin
      if (host_we) begin
         mem_q[i_host_addr] <= i_host_wdata;
      end
      if (eng.wr) begin
         mem_q[eng.wr_addr] <= eng.wr_data;
      end
   end

   ////////////////////
   // port a, host
   always_ff @(posedge clk) begin
      o_host_rdata <= mem_q[i_host_addr];
   end

   ////////////////////
   // port b, engine
   always_ff @(posedge clk) begin
      eng.rd_data <= mem_q[eng.rd_addr];
   end

endmodule

//--- rffe_if.sv
// serializer interface and frame buffer engine-port interface
`include "rffe_macros.svh"

////////////////////
// sequencer to serializer, one field per load
interface rffe_ser_if;
   logic                      load;
   logic [`RFFE_BUF_DW-1:0]   load_byte;
   logic [`RFFE_CNT_W-1:0]    nbits;
   logic                      keep_parity;
   logic                      send_parity;
   logic                      drive;
   logic                      capture;
   // final bit of the current field
   logic                      last;
   logic [`RFFE_BUF_DW-1:0]   rx_byte;

   modport seq (
      output load, load_byte, nbits, keep_parity, send_parity, drive, capture,
      input  last, rx_byte
   );
   modport ser (
      input  load, load_byte, nbits, keep_parity, send_parity, drive, capture,
      output last, rx_byte
   );
endinterface

////////////////////
// engine side of the frame buffer
interface rffe_buf_if;
   logic [`RFFE_BUF_AW-1:0]   rd_addr;
   logic [`RFFE_BUF_DW-1:0]   rd_data;
   logic                      wr;
   logic [`RFFE_BUF_AW-1:0]   wr_addr;
   logic [`RFFE_BUF_DW-1:0]   wr_data;

   modport eng (output rd_addr, wr, wr_addr, wr_data, input rd_data);
   modport mem (input rd_addr, wr, wr_addr, wr_data, output rd_data);
endinterface

//--- rffe_macros.svh
// widths, buffer map, field lengths and divider limits for the RFFE master
`ifndef RFFE_MACROS_SVH
`define RFFE_MACROS_SVH

////////////////////
// buffer geometry
`define RFFE_BUF_AW        5
`define RFFE_BUF_DW        8
`define RFFE_BUF_DEPTH     32

// buffer map, entry 0 is spare
`define RFFE_SA_ADDR       1
`define RFFE_CMD_ADDR      2
`define RFFE_REGADDR_ADDR  3
`define RFFE_DATA_BASE     4

////////////////////
// field lengths in bits
`define RFFE_SSC_BITS      2
`define RFFE_SA_BITS       4
`define RFFE_BYTE_BITS     8
`define RFFE_CNT_W         4
// start condition 1 then 0, sent MSB first
`define RFFE_SSC_PAT       8'h80

////////////////////
// bit period in clk cycles
`define RFFE_DIV_W         8
`define RFFE_DIV_MIN       2
`define RFFE_DIV_RESET     4

`endif

//--- rffe_master.f
+incdir+.
rffe_pkg.sv
rffe_if.sv
rffe_clk_div.sv
rffe_frame_buf.sv
rffe_sequencer.sv
rffe_serializer.sv
rffe_master.sv
rffe_master_checker.sv
tb_rffe_master.sv

//--- rffe_master.sv
// RFFE bus master top level, divider, buffer, sequencer and serializer
`include "rffe_macros.svh"

module rffe_master (
   input  logic                    clk,
   input  logic                    i_rst,
   // bit period
   input  logic                    i_set_div,
   input  logic [`RFFE_DIV_W-1:0]  i_div,
   // frame control
   input  logic                    i_start,
   output logic                    o_done,
   output logic                    o_busy,
   // host buffer port
   input  logic                    i_host_wr,
   input  logic [`RFFE_BUF_AW-1:0] i_host_addr,
   input  logic [`RFFE_BUF_DW-1:0] i_host_wdata,
   output logic [`RFFE_BUF_DW-1:0] o_host_rdata,
   // serial bus
   output logic                    o_sclk,
   input  logic                    i_sdi,
   output logic                    o_sdo,
   output logic                    o_sdo_en
);

   logic bit_tick;
   logic active;

   rffe_ser_if ser_bus ();
   rffe_buf_if buf_bus ();

   ////////////////////
   rffe_clk_div u_clk_div (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_set      (i_set_div),
      .i_div      (i_div),
      .i_active   (active),
      .o_bit_tick (bit_tick),
      .o_sclk     (o_sclk)
   );

   rffe_frame_buf u_frame_buf (
      .clk          (clk),
      .i_host_wr    (i_host_wr),
      .i_host_addr  (i_host_addr),
      .i_host_wdata (i_host_wdata),
      .o_host_rdata (o_host_rdata),
      .i_busy       (o_busy),
      .eng          (buf_bus.mem)
   );

   rffe_sequencer u_sequencer (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .i_bit_tick (bit_tick),
      .o_active   (active),
      .o_done     (o_done),
      .o_busy     (o_busy),
      .buf_p      (buf_bus.eng),
      .ser        (ser_bus.seq)
   );

   rffe_serializer u_serializer (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_bit_tick (bit_tick),
      .ser        (ser_bus.ser),
      .i_sdi      (i_sdi),
      .o_sdo      (o_sdo),
      .o_sdo_en   (o_sdo_en)
   );

endmodule

//--- rffe_master_checker.sv
// bound assertions for idle outputs, done pulse width and bus clock timing
`include "rffe_macros.svh"

module rffe_master_checker (
   input logic                   clk,
   input logic                   i_rst,
   input logic                   i_set_div,
   input logic [`RFFE_DIV_W-1:0] i_div,
   input logic                   o_sclk,
   input logic                   o_sdo_en,
   input logic                   o_done,
   input logic                   o_busy
);

   int                     err_cnt = 0;
   int                     hi_len;
   int                     gap;
   logic                   had_rise;
   logic [`RFFE_DIV_W-1:0] per;

   ////////////////////
   // expected period and measured sclk phases
   always_ff @(posedge clk) begin
      if (i_rst) begin
         per      <= `RFFE_DIV_W'(`RFFE_DIV_RESET);
         hi_len   <= 0;
         gap      <= 0;
         had_rise <= 1'b0;
      end else begin
         if (i_set_div) per <= (i_div < `RFFE_DIV_MIN) ? `RFFE_DIV_W'(`RFFE_DIV_MIN) : i_div;
         hi_len <= o_sclk ? hi_len + 1 : 0;
         gap    <= (o_sclk && !$past(o_sclk)) ? 1 : gap + 1;
         // only bits inside one frame are back to back
         if (!o_busy) had_rise <= 1'b0;
         else if (o_sclk) had_rise <= 1'b1;
      end
   end

   ////////////////////
   a_idle: assert property (@(posedge clk) disable iff (i_rst)
      !o_busy |-> (!o_sclk && !o_sdo_en && !o_done))
      else begin err_cnt++; $error("bus outputs active while idle"); end

   a_done: assert property (@(posedge clk) disable iff (i_rst) o_done |=> !o_done)
      else begin err_cnt++; $error("done pulse wider than one cycle"); end

   a_high: assert property (@(posedge clk) disable iff (i_rst)
      $fell(o_sclk) |-> (hi_len == int'(per) / 2))
      else begin err_cnt++; $error("sclk high phase wrong"); end

   a_period: assert property (@(posedge clk) disable iff (i_rst)
      ($rose(o_sclk) && had_rise) |-> (gap == int'(per)))
      else begin err_cnt++; $error("sclk period wrong"); end

endmodule

//--- rffe_pkg.sv
// frame states, command kinds and the command decoder
`include "rffe_macros.svh"

package rffe_pkg;

   // one state per frame field
   typedef enum logic [2:0] {
      IDLE = 3'd0,
      SSC  = 3'd1,
      SA   = 3'd2,
      CMD  = 3'd3,
      ADDR = 3'd4,
      PARK = 3'd5,
      DATA = 3'd6,
      END  = 3'd7
   } frame_state_e;

   typedef enum logic [2:0] {
      REG0_WR,
      REG_WR,
      REG_RD,
      EXT_WR,
      EXT_RD,
      INVALID
   } cmd_kind_e;

   // standard command byte patterns, top bits first
   function automatic cmd_kind_e decode_cmd(input logic [`RFFE_BUF_DW-1:0] cmd);
      if (cmd[7])                   return REG0_WR;
      else if (cmd[7:5] == 3'b010)  return REG_WR;
      else if (cmd[7:5] == 3'b011)  return REG_RD;
      else if (cmd[7:4] == 4'b0000) return EXT_WR;
      else if (cmd[7:4] == 4'b0010) return EXT_RD;
      else                          return INVALID;
   endfunction

endpackage

//--- rffe_sequencer.sv
// frame state machine, buffer addressing and byte counting
`include "rffe_macros.svh"

module rffe_sequencer (
   input  logic   clk,
   input  logic   i_rst,
   input  logic   i_start,
   input  logic   i_bit_tick,
   output logic   o_active,
   output logic   o_done,
   output logic   o_busy,
   rffe_buf_if.eng buf_p,
   rffe_ser_if.seq ser
);

   rffe_pkg::frame_state_e  state_q;
   rffe_pkg::frame_state_e  state_nx;
   rffe_pkg::cmd_kind_e     kind_q;
   logic [`RFFE_BUF_DW-1:0] cmd_q;
   logic [`RFFE_CNT_W-1:0]  left_q;
   logic [`RFFE_BUF_AW-1:0] ptr_q;
   logic                    start_q;
   logic                    data_done_q;
   logic                    is_rd;
   logic                    is_ext;
   logic                    step;

   assign is_rd  = (kind_q == rffe_pkg::REG_RD) || (kind_q == rffe_pkg::EXT_RD);
   assign is_ext = (kind_q == rffe_pkg::EXT_WR) || (kind_q == rffe_pkg::EXT_RD);
   // field boundary
   assign step   = i_bit_tick && ser.last;

   ////////////////////
   // next field choice
   always_comb begin
      state_nx        = state_q;
      ser.load        = 1'b0;
      ser.load_byte   = '0;
      ser.nbits       = `RFFE_CNT_W'(1);
      ser.keep_parity = 1'b0;
      ser.send_parity = 1'b0;
      case (state_q)
         rffe_pkg::IDLE: begin
            if (i_bit_tick && start_q) begin
               state_nx      = rffe_pkg::SSC;
               ser.load      = 1'b1;
               ser.load_byte = `RFFE_SSC_PAT;
               ser.nbits     = `RFFE_CNT_W'(`RFFE_SSC_BITS);
            end
         end
         rffe_pkg::SSC: begin
            if (step) begin
               state_nx      = rffe_pkg::SA;
               ser.load      = 1'b1;
               ser.load_byte = {buf_p.rd_data[`RFFE_SA_BITS-1:0], 4'b0000};
               ser.nbits     = `RFFE_CNT_W'(`RFFE_SA_BITS);
            end
         end
         rffe_pkg::SA: begin
            // parity of the command covers the SA too
            if (step) begin
               state_nx        = rffe_pkg::CMD;
               ser.load        = 1'b1;
               ser.load_byte   = (kind_q == rffe_pkg::REG0_WR) ?
                                 {cmd_q[7], buf_p.rd_data[6:0]} : cmd_q;
               ser.nbits       = `RFFE_CNT_W'(`RFFE_BYTE_BITS);
               ser.keep_parity = 1'b1;
               ser.send_parity = 1'b1;
            end
         end
         rffe_pkg::CMD: begin
            if (step) begin
               ser.load = 1'b1;
               case (kind_q)
                  rffe_pkg::REG0_WR,
                  rffe_pkg::REG_RD:  state_nx = rffe_pkg::PARK;
                  rffe_pkg::REG_WR:  state_nx = rffe_pkg::DATA;
                  rffe_pkg::EXT_WR,
                  rffe_pkg::EXT_RD:  state_nx = rffe_pkg::ADDR;
                  // no park bit after a bad command
                  default:           state_nx = rffe_pkg::END;
               endcase
               if (kind_q == rffe_pkg::REG_WR || is_ext) begin
                  ser.load_byte   = buf_p.rd_data;
                  ser.nbits       = `RFFE_CNT_W'(`RFFE_BYTE_BITS);
                  ser.send_parity = 1'b1;
               end
            end
         end
         rffe_pkg::ADDR: begin
            if (step) begin
               ser.load = 1'b1;
               if (is_rd) begin
                  state_nx = rffe_pkg::PARK;
               end else begin
                  state_nx        = rffe_pkg::DATA;
                  ser.load_byte   = buf_p.rd_data;
                  ser.nbits       = `RFFE_CNT_W'(`RFFE_BYTE_BITS);
                  ser.send_parity = 1'b1;
               end
            end
         end
         rffe_pkg::PARK: begin
            if (step) begin
               ser.load = 1'b1;
               if (is_rd && !data_done_q) begin
                  // slave's data and parity, shifted in
                  state_nx        = rffe_pkg::DATA;
                  ser.nbits       = `RFFE_CNT_W'(`RFFE_BYTE_BITS);
                  ser.send_parity = 1'b1;
               end else begin
                  state_nx = rffe_pkg::END;
               end
            end
         end
         rffe_pkg::DATA: begin
            if (step) begin
               ser.load = 1'b1;
               if (left_q == '0) begin
                  state_nx = rffe_pkg::PARK;
               end else begin
                  ser.load_byte   = is_rd ? '0 : buf_p.rd_data;
                  ser.nbits       = `RFFE_CNT_W'(`RFFE_BYTE_BITS);
                  ser.send_parity = 1'b1;
               end
            end
         end
         rffe_pkg::END: begin
            if (i_bit_tick) state_nx = rffe_pkg::IDLE;
         end
         default: state_nx = rffe_pkg::IDLE;
      endcase
   end

   ////////////////////
   // control registers
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q     <= rffe_pkg::IDLE;
         kind_q      <= rffe_pkg::INVALID;
         left_q      <= '0;
         ptr_q       <= `RFFE_BUF_AW'(`RFFE_CMD_ADDR);
         start_q     <= 1'b0;
         data_done_q <= 1'b0;
      end else begin
         state_q <= state_nx;
         if (i_start) start_q <= 1'b1;
         else if (i_bit_tick) start_q <= 1'b0;
         if (state_q == rffe_pkg::IDLE) begin
            // command byte fetched first
            ptr_q       <= `RFFE_BUF_AW'(`RFFE_CMD_ADDR);
            data_done_q <= 1'b0;
         end else if (i_bit_tick && state_q == rffe_pkg::SSC && !ser.last) begin
            kind_q <= rffe_pkg::decode_cmd(buf_p.rd_data);
            ptr_q  <= `RFFE_BUF_AW'(`RFFE_SA_ADDR);
         end else if (step) begin
            case (state_q)
               rffe_pkg::SSC: ptr_q <= is_ext ? `RFFE_BUF_AW'(`RFFE_REGADDR_ADDR) :
                                                `RFFE_BUF_AW'(`RFFE_DATA_BASE);
               rffe_pkg::CMD: begin
                  left_q <= is_ext ? cmd_q[`RFFE_CNT_W-1:0] : '0;
                  if (is_ext) ptr_q <= `RFFE_BUF_AW'(`RFFE_DATA_BASE);
                  else if (kind_q == rffe_pkg::REG_WR) ptr_q <= ptr_q + 1'b1;
               end
               rffe_pkg::ADDR: if (!is_rd) ptr_q <= ptr_q + 1'b1;
               rffe_pkg::DATA: begin
                  ptr_q <= ptr_q + 1'b1;
                  if (left_q == '0) data_done_q <= 1'b1;
                  else left_q <= left_q - 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // command byte, taken during the start condition
   always_ff @(posedge clk) begin
      if (i_bit_tick && state_q == rffe_pkg::SSC && !ser.last) cmd_q <= buf_p.rd_data;
   end

   ////////////////////
   // field controls and outputs
   assign ser.drive   = (state_q inside {rffe_pkg::SSC, rffe_pkg::SA, rffe_pkg::CMD,
                                         rffe_pkg::ADDR}) ||
                        (state_q == rffe_pkg::DATA && !is_rd);
   assign ser.capture = (state_q == rffe_pkg::DATA) && is_rd;
   assign o_active    = state_q inside {rffe_pkg::SA, rffe_pkg::CMD, rffe_pkg::ADDR,
                                        rffe_pkg::PARK, rffe_pkg::DATA};
   assign o_busy      = (state_q != rffe_pkg::IDLE);
   assign o_done      = (state_q == rffe_pkg::END) && i_bit_tick;

   // read bytes land at DATA_BASE onward
   assign buf_p.rd_addr = ptr_q;
   assign buf_p.wr_addr = ptr_q;
   assign buf_p.wr      = step && ser.capture;
   assign buf_p.wr_data = ser.rx_byte;

endmodule

//--- rffe_serializer.sv
// shift register, running odd parity, sdo/sdo_en drive and sdi capture
`include "rffe_macros.svh"

module rffe_serializer (
   input  logic   clk,
   input  logic   i_rst,
   input  logic   i_bit_tick,
   rffe_ser_if.ser ser,
   input  logic   i_sdi,
   output logic   o_sdo,
   output logic   o_sdo_en
);

   logic [`RFFE_BUF_DW-1:0] sh_q;
   logic [`RFFE_CNT_W-1:0]  bcnt_q;
   logic                    par_q;
   logic                    slot_q;
   logic                    sp_q;
   logic                    acc;

   // parity including the bit now on the wire
   assign acc = slot_q ? par_q : (par_q ^ sh_q[`RFFE_BUF_DW-1]);

   ////////////////////
   // bit counter, parity and parity slot
   always_ff @(posedge clk) begin
      if (i_rst) begin
         bcnt_q <= '0;
         par_q  <= 1'b0;
         slot_q <= 1'b0;
         sp_q   <= 1'b0;
      end else if (i_bit_tick) begin
         if (ser.load) begin
            bcnt_q <= ser.nbits - 1'b1;
            slot_q <= 1'b0;
            sp_q   <= ser.send_parity;
            par_q  <= ser.keep_parity ? acc : 1'b0;
         end else if (!slot_q) begin
            if (bcnt_q != '0) bcnt_q <= bcnt_q - 1'b1;
            else if (sp_q) slot_q <= 1'b1;
            if (ser.drive) par_q <= acc;
         end
      end
   end

   ////////////////////
   // MSB first out, sdi in at the LSB
   always_ff @(posedge clk) begin
      if (i_bit_tick) begin
         if (ser.load) begin
            sh_q <= ser.load_byte;
         end else if (!slot_q) begin
            sh_q <= {sh_q[`RFFE_BUF_DW-2:0], ser.capture ? i_sdi : 1'b0};
         end
      end
   end

   assign ser.last    = slot_q || (bcnt_q == '0 && !sp_q);
   assign ser.rx_byte = sh_q;

   // odd parity, inverted running xor
   assign o_sdo    = ser.drive && (slot_q ? !par_q : sh_q[`RFFE_BUF_DW-1]);
   assign o_sdo_en = ser.drive;

endmodule

//--- tb_rffe_master.sv
// testbench for the RFFE master with slave model, frame compare and watchdog
`include "rffe_macros.svh"

module tb_rffe_master;

   localparam int WATCHDOG = 5 * 170 * 7 * 20;

   logic       clk = 1'b0;
   logic       i_rst, i_set_div, i_start, i_host_wr, i_sdi;
   logic [7:0] i_div, i_host_wdata, o_host_rdata;
   logic [4:0] i_host_addr;
   logic       o_done, o_busy, o_sclk, o_sdo, o_sdo_en;
   integer     seed;
   bit         exp_q[$];
   bit         got_q[$];
   bit         run_par;
   int         slave_k;
   logic       sclk_d = 1'b0;
   logic       sclk_seen = 1'b0;
   logic [7:0] sa, cmd, ra, d0, d1, d2;

   always #10 clk = ~clk;

   rffe_master u_rffe_master (.*);
   bind rffe_master rffe_master_checker u_chk (.*);

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   function automatic logic [7:0] slave_byte(input int j);
      return 8'h3C + 8'(j * 17);
   endfunction

   // park bit first, then data bits and a parity slot per byte
   function automatic logic slave_bit(input int k);
      logic [7:0] pat;
      if (k == 0 || (k - 1) % 9 == 8) return 1'b0;
      pat = slave_byte((k - 1) / 9);
      return pat[7 - (k - 1) % 9];
   endfunction

   ////////////////////
   // bus monitor and slave model
   always @(negedge clk) begin
      if (!o_busy) begin
         slave_k   = 0;
         sclk_seen = 1'b0;
      end else if (o_sclk && !sclk_d) begin
         sclk_seen = 1'b1;
         if (o_sdo_en) got_q.push_back(o_sdo);
         else begin
            i_sdi = slave_bit(slave_k);
            slave_k++;
         end
      end else if (!sclk_seen && o_sdo_en && u_rffe_master.bit_tick) begin
         // start condition bits, sclk still quiet
         got_q.push_back(o_sdo);
      end
      sclk_d = o_sclk;
      if (u_rffe_master.u_chk.err_cnt != 0) fail_now("a bound assertion failed");
   end

   initial begin
      #(WATCHDOG);
      $display("watchdog expired before the tests finished");
      $display("Checks failed");
      $fatal(1);
   end

   task automatic host_write(input logic [4:0] a, input logic [7:0] d);
      @(negedge clk);
      i_host_addr  = a;
      i_host_wdata = d;
      i_host_wr    = 1'b1;
      @(negedge clk);
      i_host_wr = 1'b0;
   endtask

   task automatic host_check(input string name, input logic [4:0] a, input logic [7:0] e);
      @(negedge clk);
      i_host_addr = a;
      @(negedge clk);
      assert (o_host_rdata == e)
         else fail_now($sformatf("** Error %s expected %0h actual %0h", name, e, o_host_rdata));
   endtask

   task automatic set_div(input logic [7:0] d);
      @(negedge clk);
      i_set_div = 1'b1;
      i_div     = d;
      @(negedge clk);
      i_set_div = 1'b0;
   endtask

   // field bits MSB first, odd parity over the running count
   task automatic add_bits(input logic [7:0] v, input int n, input bit keep, input bit par);
      if (!keep) run_par = 1'b0;
      for (int i = 0; i < n; i++) begin
         exp_q.push_back(v[7 - i]);
         run_par ^= v[7 - i];
      end
      if (par) exp_q.push_back(~run_par);
   endtask

   task automatic run_frame(input string name, input bit lock);
      got_q.delete();
      // start condition, one bit high then one bit low
      exp_q.push_front(1'b0);
      exp_q.push_front(1'b1);
      @(negedge clk);
      i_start = 1'b1;
      @(negedge clk);
      i_start = 1'b0;
      if (lock) begin
         while (!o_busy) @(negedge clk);
         host_write(`RFFE_DATA_BASE, 8'hEE);
      end
      while (!o_done) @(negedge clk);
      assert (got_q.size() == exp_q.size())
         else fail_now($sformatf("** Error %s expected %0d actual %0d", name,
                                 exp_q.size(), got_q.size()));
      for (int i = 0; i < exp_q.size(); i++) begin
         assert (got_q[i] == exp_q[i])
            else fail_now($sformatf("** Error %s expected %0h actual %0h", name,
                                    exp_q[i], got_q[i]));
      end
      exp_q.delete();
   endtask

   ////////////////////
   initial begin
      seed = 13;
      {i_rst, i_set_div, i_start, i_host_wr, i_sdi} = 5'b10000;
      {i_div, i_host_wdata, i_host_addr} = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;
      sa = 8'($random(seed)) & 8'h0F;
      ra = 8'($random(seed));
      d0 = 8'($random(seed));
      d1 = 8'($random(seed));
      d2 = 8'($random(seed));
      host_write(`RFFE_SA_ADDR, sa);

      // register write, divider 1 clamps to 2
      set_div(8'd1);
      cmd = {3'b010, ra[4:0]};
      host_write(`RFFE_CMD_ADDR, cmd);
      host_write(`RFFE_DATA_BASE, d0);
      add_bits({sa[3:0], 4'h0}, 4, 0, 0);
      add_bits(cmd, 8, 1, 1);
      add_bits(d0, 8, 0, 1);
      run_frame("reg_write", 1'b0);

      // register-0 write with a locked host write
      set_div(8'd7);
      cmd = {1'b1, ra[6:0]};
      host_write(`RFFE_CMD_ADDR, cmd);
      add_bits({sa[3:0], 4'h0}, 4, 0, 0);
      add_bits({1'b1, d0[6:0]}, 8, 1, 1);
      run_frame("reg0_write", 1'b1);
      host_check("busy_lock", `RFFE_DATA_BASE, d0);

      // extended write, three bytes
      set_div(8'd2);
      host_write(`RFFE_CMD_ADDR, 8'h02);
      host_write(`RFFE_REGADDR_ADDR, ra);
      host_write(5'(`RFFE_DATA_BASE + 1), d1);
      host_write(5'(`RFFE_DATA_BASE + 2), d2);
      add_bits({sa[3:0], 4'h0}, 4, 0, 0);
      add_bits(8'h02, 8, 1, 1);
      add_bits(ra, 8, 0, 1);
      add_bits(d0, 8, 0, 1);
      add_bits(d1, 8, 0, 1);
      add_bits(d2, 8, 0, 1);
      run_frame("ext_write", 1'b0);

      // register read
      cmd = {3'b011, ra[4:0]};
      host_write(`RFFE_CMD_ADDR, cmd);
      add_bits({sa[3:0], 4'h0}, 4, 0, 0);
      add_bits(cmd, 8, 1, 1);
      run_frame("reg_read", 1'b0);
      host_check("reg_read_data", `RFFE_DATA_BASE, slave_byte(0));

      // extended read, three bytes
      host_write(`RFFE_CMD_ADDR, 8'h22);
      add_bits({sa[3:0], 4'h0}, 4, 0, 0);
      add_bits(8'h22, 8, 1, 1);
      add_bits(ra, 8, 0, 1);
      run_frame("ext_read", 1'b0);
      for (int j = 0; j < 3; j++) begin
         host_check("ext_read_data", 5'(`RFFE_DATA_BASE + j), slave_byte(j));
      end

      repeat (4) @(negedge clk);
      if (u_rffe_master.u_chk.err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
